/* source/mlp_pkg.sv */
package mlp_pkg;

    // engine sizes
    localparam int NUM_NEURON  = 4;   // neurons per layer, also number of engine inputs
    localparam int LAYER_MAX   = 3;   // fully connected layers
    localparam int INPUT_SIZE  = 8;   // neuron input / output width, signed
    localparam int WEIGHT_SIZE = 8;   // weight width, signed
    localparam int ACC_SIZE    = 20;  // holds NUM_NEURON full products with headroom
    localparam int FRAC_BITS   = 4;   // fixed-point shift after accumulation
    localparam int LAYER_W     = 2;   // layer index width

    // fixed-point words
    typedef logic signed [INPUT_SIZE-1:0]  data_t;
    typedef logic signed [WEIGHT_SIZE-1:0] weight_t;

    // whole layer of neuron values, element k belongs to neuron k
    typedef data_t [NUM_NEURON-1:0] neuron_vec_t;

    // weights into one neuron, element j multiplies input j
    typedef weight_t [NUM_NEURON-1:0] weight_row_t;

    // one layer's matrix, row k feeds neuron k
    typedef weight_row_t [NUM_NEURON-1:0] weight_mat_t;

    typedef logic [NUM_NEURON-1:0] mask_t;  // bit k enables neuron k

    // active neurons per layer, index 0 is layer 0
    // the last layer only uses the lower three neurons
    localparam mask_t [LAYER_MAX-1:0] LAYER_MASKS = {
        mask_t'(3'b111),
        {NUM_NEURON{1'b1}},
        {NUM_NEURON{1'b1}}
    };

    // weight image, one hex line per layer starting with layer 0
    // each line is a full weight_mat_t, so the leftmost byte is
    // row NUM_NEURON-1 weight NUM_NEURON-1 and the rightmost is row 0 weight 0
    localparam string WEIGHTS_FILE = "source/weights.mem";

endpackage

/* source/weight_rom.sv */
`timescale 1ns/1ps

module weight_rom (
    input  logic                         clk,
    input  logic [mlp_pkg::LAYER_W-1:0]  addr,   // layer index
    output mlp_pkg::weight_mat_t         rdata   // whole matrix, one cycle after addr
);

    import mlp_pkg::*;

    // one matrix per layer
    weight_mat_t mem [LAYER_MAX];

    // image comes from the hex file, nothing writes it afterwards
    initial begin
        $readmemh(WEIGHTS_FILE, mem);
    end

    // read port is always enabled, the sequencer just steers addr
    always_ff @(posedge clk) begin
        rdata <= mem[addr];  // registered read, maps onto block ram
    end

endmodule

/* source/neuron_unit.sv */
`timescale 1ns/1ps

module neuron_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  layer_start,  // one-cycle kick, broadcast
    input  logic                  active,       // low forces a zero result
    input  mlp_pkg::neuron_vec_t  inputs,       // previous layer outputs
    input  mlp_pkg::weight_row_t  weights,      // this neuron's row of the matrix
    output mlp_pkg::data_t        result,
    output logic                  valid         // level, held until next layer_start
);

    import mlp_pkg::*;

    neuron_vec_t                       in_sr;    // operands still to consume
    weight_row_t                       w_sr;
    logic signed [ACC_SIZE-1:0]        acc;
    logic [$clog2(NUM_NEURON+1)-1:0]   step;     // products already summed
    logic                              run;

    data_t                             in_head;
    weight_t                           w_head;
    logic signed [ACC_SIZE-1:0]        acc_base;
    logic signed [ACC_SIZE-1:0]        acc_sum;
    logic signed [ACC_SIZE-1:0]        shifted;
    logic                              last_step;
    data_t                             sat_value;

    // the first product is taken straight from the ports on the layer_start edge,
    // so the shift registers only need to supply the remaining operands
    assign in_head  = layer_start ? inputs[0]  : in_sr[0];
    assign w_head   = layer_start ? weights[0] : w_sr[0];
    assign acc_base = layer_start ? '0 : acc;   // fresh sum for a new layer
    assign acc_sum  = acc_base + in_head * w_head;

    assign last_step = run && (step == NUM_NEURON);

    assign shifted = acc >>> FRAC_BITS;  // arithmetic, keeps the sign

    // relu then clamp to the largest positive data_t
    always_comb begin
        if (!active || shifted[ACC_SIZE-1]) begin
            sat_value = '0;
        end else if (|shifted[ACC_SIZE-2:INPUT_SIZE-1]) begin
            sat_value = {1'b0, {(INPUT_SIZE-1){1'b1}}};
        end else begin
            sat_value = shifted[INPUT_SIZE-1:0];
        end
    end

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            run   <= 1'b0;
            step  <= '0;
            valid <= 1'b0;
        end else if (layer_start) begin
            run   <= 1'b1;
            step  <= 1'b1;   // product 0 goes in on this edge
            valid <= 1'b0;   // drop the previous layer's result
        end else if (last_step) begin
            run   <= 1'b0;
            valid <= 1'b1;
        end else if (run) begin
            step <= step + 1'b1;
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (layer_start) begin
            in_sr <= inputs >> INPUT_SIZE;
            w_sr  <= weights >> WEIGHT_SIZE;
            acc   <= acc_sum;
        end else if (run && !last_step) begin
            in_sr <= in_sr >> INPUT_SIZE;
            w_sr  <= w_sr >> WEIGHT_SIZE;
            acc   <= acc_sum;
        end

        if (last_step) begin
            result <= sat_value;  // shift, relu and saturate stage
        end
    end

endmodule

/* source/layer_sequencer.sv */
`timescale 1ns/1ps

module layer_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,           // ignored while busy
    input  mlp_pkg::neuron_vec_t         in_data,         // engine inputs, taken on start
    input  mlp_pkg::weight_mat_t         rom_data,
    input  mlp_pkg::neuron_vec_t         neuron_results,
    input  mlp_pkg::mask_t               neuron_valid,
    output logic [mlp_pkg::LAYER_W-1:0]  rom_addr,
    output mlp_pkg::neuron_vec_t         layer_inputs,    // broadcast to every neuron
    output mlp_pkg::weight_mat_t         layer_weights,   // row k to neuron k
    output mlp_pkg::mask_t               active,
    output logic                         layer_start,
    output logic [mlp_pkg::LAYER_W-1:0]  layer_num,
    output logic                         busy,
    output logic                         done,
    output mlp_pkg::neuron_vec_t         final_output
);

    import mlp_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,   // rom output for the new layer gets registered
        FIRE,   // latch weights and mask, kick the neurons
        WAIT    // wait for every active neuron
    } state_t;

    state_t               state;
    logic [LAYER_W-1:0]   layer;
    logic                 last_layer;
    logic                 layer_done;

    assign rom_addr  = layer;
    assign layer_num = layer;

    assign last_layer = (layer == LAYER_W'(LAYER_MAX - 1));

    // only the enabled neurons count toward completion
    // during the layer_start cycle the neurons still show the previous
    // layer's valid, so that cycle is skipped
    assign layer_done = !layer_start && ((neuron_valid & active) == active);

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            layer        <= '0;
            active       <= '0;
            layer_start  <= 1'b0;
            busy         <= 1'b0;
            done         <= 1'b0;
            final_output <= '0;
        end else begin
            layer_start <= 1'b0;  // both are single-cycle pulses
            done        <= 1'b0;

            case (state)
                IDLE: begin
                    if (start) begin
                        layer <= '0;
                        busy  <= 1'b1;
                        state <= LOAD;
                    end
                end

                LOAD: begin
                    state <= FIRE;  // rom_addr already points at this layer
                end

                FIRE: begin
                    active      <= LAYER_MASKS[layer];
                    layer_start <= 1'b1;
                    state       <= WAIT;
                end

                WAIT: begin
                    if (layer_done) begin
                        if (last_layer) begin
                            final_output <= neuron_results;
                            done         <= 1'b1;
                            busy         <= 1'b0;
                            layer        <= '0;
                            state        <= IDLE;
                        end else begin
                            layer <= layer + 1'b1;
                            state <= LOAD;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // layer operand buffers
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            layer_inputs <= in_data;                   // first layer sees the engine inputs
        end else if (state == WAIT && layer_done && !last_layer) begin
            layer_inputs <= neuron_results;            // feed forward
        end

        if (state == FIRE) begin
            layer_weights <= rom_data;
        end
    end

endmodule

/* source/mlp_top.sv */
`timescale 1ns/1ps

module mlp_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  mlp_pkg::neuron_vec_t         in_data,
    output logic                         busy,
    output logic                         done,
    output mlp_pkg::neuron_vec_t         final_output,  // valid with done, held until next
    output logic [mlp_pkg::LAYER_W-1:0]  layer_num
);

    import mlp_pkg::*;

    logic [LAYER_W-1:0]  rom_addr;
    weight_mat_t         rom_data;

    neuron_vec_t         layer_inputs;
    weight_mat_t         layer_weights;
    mask_t               active;
    logic                layer_start;

    neuron_vec_t         neuron_results;  // gathered from the neuron array
    mask_t               neuron_valid;

    layer_sequencer layer_sequencer_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .in_data        (in_data),
        .rom_data       (rom_data),
        .neuron_results (neuron_results),
        .neuron_valid   (neuron_valid),
        .rom_addr       (rom_addr),
        .layer_inputs   (layer_inputs),
        .layer_weights  (layer_weights),
        .active         (active),
        .layer_start    (layer_start),
        .layer_num      (layer_num),
        .busy           (busy),
        .done           (done),
        .final_output   (final_output)
    );

    weight_rom weight_rom_i (
        .clk   (clk),
        .addr  (rom_addr),
        .rdata (rom_data)
    );

    // shared neuron array, reused by every layer
    for (genvar k = 0; k < NUM_NEURON; k++) begin : g_neuron
        neuron_unit neuron_unit_i (
            .clk         (clk),
            .rst         (rst),
            .layer_start (layer_start),
            .active      (active[k]),
            .inputs      (layer_inputs),
            .weights     (layer_weights[k]),   // row k of the matrix
            .result      (neuron_results[k]),
            .valid       (neuron_valid[k])
        );
    end

endmodule

/* verif/mlp_chk.sv */
`timescale 1ns/1ps

module mlp_chk (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         layer_start,
    input  logic                         busy,
    input  logic                         done,
    input  logic [mlp_pkg::LAYER_W-1:0]  layer_num
);

    import mlp_pkg::*;

    int fails = 0;  // read by the testbench at the end

    // neuron kick is one cycle wide
    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        layer_start |=> !layer_start)
    else begin
        $error("layer_start high for more than one cycle");
        fails++;
    end

    a_start_busy: assert property (@(posedge clk) disable iff (rst)
        layer_start |-> busy)
    else begin
        $error("layer_start while not busy");
        fails++;
    end

    a_layer_range: assert property (@(posedge clk) disable iff (rst)
        layer_num < LAYER_MAX)
    else begin
        $error("layer_num out of range");
        fails++;
    end

    // engine is idle right after the result goes out
    a_done_idle: assert property (@(posedge clk) disable iff (rst)
        done |=> !busy)
    else begin
        $error("busy still high after done");
        fails++;
    end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!layer_start && !done))
    else begin
        $error("layer_start or done high after reset");
        fails++;
    end

endmodule

/* verif/mlp_tb.sv */
`timescale 1ns/1ps

module mlp_tb;

    import mlp_pkg::*;

    localparam int N_RANDOM   = 20;
    localparam int N_INFER    = 26;  // all starts accepted by the engine, aborted one included
    localparam int LAYER_CYC  = NUM_NEURON + 4;
    localparam int MAX_CYCLES = (N_INFER + 4) * LAYER_MAX * LAYER_CYC * 2;
    localparam int DATA_MAX   = (2 ** (INPUT_SIZE - 1)) - 1;

    logic                clk;
    logic                rst;
    logic                start;
    neuron_vec_t         in_data;
    logic                busy;
    logic                done;
    neuron_vec_t         final_output;
    logic [LAYER_W-1:0]  layer_num;

    weight_mat_t         w_mem [LAYER_MAX];  // same image as the rom
    neuron_vec_t         exp_q [$];          // expected results in start order
    logic [31:0]         rng_state;
    logic [LAYER_W-1:0]  last_layer_num;     // layer_num one cycle back
    int                  errors = 0;
    int                  accepted = 0;
    int                  done_count = 0;
    int                  cycles = 0;

    mlp_top mlp_top_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .in_data      (in_data),
        .busy         (busy),
        .done         (done),
        .final_output (final_output),
        .layer_num    (layer_num)
    );

    bind layer_sequencer mlp_chk mlp_chk_i (
        .clk         (clk),
        .rst         (rst),
        .layer_start (layer_start),
        .busy        (busy),
        .done        (done),
        .layer_num   (layer_num)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected result, layer by layer: mac, shift, relu, saturate, mask
    function automatic neuron_vec_t mlp_ref(input neuron_vec_t x);
        neuron_vec_t cur;
        neuron_vec_t nxt;
        int          acc;
        int          shifted;
        cur = x;
        for (int l = 0; l < LAYER_MAX; l++) begin
            for (int k = 0; k < NUM_NEURON; k++) begin
                acc = 0;
                for (int j = 0; j < NUM_NEURON; j++) begin
                    acc += int'(cur[j]) * int'(w_mem[l][k][j]);
                end
                shifted = acc >>> FRAC_BITS;
                if (!LAYER_MASKS[l][k] || shifted < 0) begin
                    nxt[k] = '0;
                end else if (shifted > DATA_MAX) begin
                    nxt[k] = data_t'(DATA_MAX);
                end else begin
                    nxt[k] = data_t'(shifted);
                end
            end
            cur = nxt;
        end
        return cur;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic random_vec(output neuron_vec_t v);
        for (int k = 0; k < NUM_NEURON; k++) begin
            rng_state = lcg_next(rng_state);
            v[k] = data_t'(rng_state[23:16]);  // upper bits, better spread
        end
    endtask

    function automatic neuron_vec_t fill_vec(input data_t d);
        neuron_vec_t v;
        for (int k = 0; k < NUM_NEURON; k++) begin
            v[k] = d;
        end
        return v;
    endfunction

    task automatic check_output(input neuron_vec_t got, input neuron_vec_t exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_layer(input logic [LAYER_W-1:0] got, input logic [LAYER_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic pulse_start(input neuron_vec_t v);
        @(posedge clk);
        start   <= 1'b1;
        in_data <= v;
        @(posedge clk);
        start   <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    // a start the engine will accept, result goes on the queue
    task automatic run_inference(input neuron_vec_t v);
        exp_q.push_back(mlp_ref(v));
        accepted++;
        pulse_start(v);
        wait_done();
    endtask

    task automatic finish_run();
        errors += mlp_top_i.layer_sequencer_i.mlp_chk_i.fails;
        $display("errors: %0d, results compared: %0d, accepted starts: %0d",
                 errors, done_count, accepted);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // compare every result as it comes out
    always @(negedge clk) begin
        if (!rst && done) begin
            done_count++;
            // the result comes out of the last layer
            check_layer(last_layer_num, LAYER_W'(LAYER_MAX - 1), "layer_num before done");
            if (exp_q.size() == 0) begin
                errors++;
                $display("done pulse at %0t without an accepted start", $time);
            end else begin
                check_output(final_output, exp_q.pop_front(), "final_output");
            end
        end
        last_layer_num = layer_num;
    end

    initial begin : timeout
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation timed out after %0d cycles", cycles);
        errors++;
        finish_run();
    end

    initial begin : main
        neuron_vec_t v;
        rst       = 1'b1;
        start     = 1'b0;
        in_data   = '0;
        rng_state = 32'hd0c3;
        $readmemh(WEIGHTS_FILE, w_mem);
        if ($isunknown(w_mem[LAYER_MAX-1])) begin
            errors++;
            $display("weight file %s could not be read", WEIGHTS_FILE);
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_layer(layer_num, '0, "layer_num after reset");
        check_output(final_output, '0, "final_output after reset");

        // small fixed inputs
        v = '{8'sd48, -8'sd8, 8'sd32, 8'sd16};
        run_inference(v);

        for (int n = 0; n < N_RANDOM; n++) begin
            random_vec(v);
            run_inference(v);
        end

        // saturation and negative clamp
        run_inference(fill_vec(data_t'(DATA_MAX)));
        run_inference(fill_vec(data_t'(-DATA_MAX - 1)));

        // starts while busy are dropped
        random_vec(v);
        exp_q.push_back(mlp_ref(v));
        accepted++;
        pulse_start(v);
        @(negedge clk);
        check_flag(busy, 1'b1, "busy after accepted start");
        repeat (2) @(posedge clk);
        pulse_start(fill_vec(8'sd5));
        repeat (8) @(posedge clk);
        pulse_start(fill_vec(-8'sd7));
        wait_done();

        // reset in the middle of a layer, this one is never queued
        random_vec(v);
        pulse_start(v);
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after mid-run reset");
        check_layer(layer_num, '0, "layer_num after mid-run reset");
        repeat (4 * LAYER_CYC) @(negedge clk);  // long enough for a stray done
        check_count(done_count, accepted, "done pulses after mid-run reset");

        random_vec(v);
        run_inference(v);

        repeat (3) @(negedge clk);
        check_count(done_count, accepted, "done pulses");
        check_count(exp_q.size(), 0, "results never delivered");
        finish_run();
    end

endmodule

/* source/weights.mem */
// one 128-bit matrix per line, layer 0 first, row 3 weight 3 leftmost, row 0 weight 0 rightmost
E8100C0820F4060AFC0C18F00408F810
F008F82010101010F40C14FC0810F018
30303030F81C080C1808F40A0CF81014

/* verilog.f */
source/mlp_pkg.sv
source/weight_rom.sv
source/neuron_unit.sv
source/layer_sequencer.sv
source/mlp_top.sv
verif/mlp_chk.sv
verif/mlp_tb.sv

/* Bender.yml */
package:
  name: mlp_engine

sources:
  - source/mlp_pkg.sv
  - source/weight_rom.sv
  - source/neuron_unit.sv
  - source/layer_sequencer.sv
  - source/mlp_top.sv
  - target: test
    files:
      - verif/mlp_chk.sv
      - verif/mlp_tb.sv
